//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cart_loader -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- src/backup_sector_sequencer.sv
// Backup RAM sector sequencer issuing card reads or writes over the RAM range
`timescale 1ns/1ps
`default_nettype none

module backup_sector_sequencer (
	input  wire                              clk_sys,
	input  wire                              RESET,
	input  wire                              start_load,
	input  wire                              start_save,
	input  wire  cart_pkg::mask_t            ram_mask,
	input  wire                              sd_ack,
	output logic [cart_pkg::SD_LBA_W-1:0]    sd_lba,
	output logic                             sd_rd,
	output logic                             sd_wr,
	output logic                             bk_loading
);

	import cart_pkg::*;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_REQUEST,
		SEQ_TRANSFER
	} seq_state_t;

	seq_state_t                  state;
	logic                        old_ack;
	logic                        ack_rise;
	logic                        ack_fall;
	logic [23-SECTOR_SHIFT:0]    last_sector;

	assign ack_rise    = sd_ack & ~old_ack;
	assign ack_fall    = ~sd_ack & old_ack;
	assign last_sector = ram_mask[23:SECTOR_SHIFT];

	// ========================================================================
	// Sector FSM
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= SEQ_IDLE;
			old_ack    <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_ack <= sd_ack;
			case (state)
				SEQ_IDLE: begin
					// Load wins over a save in the same cycle
					if (start_load || start_save) begin
						sd_lba     <= '0;
						bk_loading <= start_load;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
						state      <= SEQ_REQUEST;
					end
				end
				SEQ_REQUEST: begin
					// Card has taken the request
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= SEQ_TRANSFER;
					end
				end
				SEQ_TRANSFER: begin
					if (ack_fall) begin
						if (sd_lba >= SD_LBA_W'(last_sector)) begin
							bk_loading <= 1'b0;
							state      <= SEQ_IDLE;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
							state  <= SEQ_REQUEST;
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/cart_load_ctrl.sv
// Load control that decodes downloads, tracks backup enable and builds the system reset
`timescale 1ns/1ps
`default_nettype none

module cart_load_ctrl (
	input  wire                              clk_sys,
	input  wire                              RESET,
	input  wire                              ioctl_download,
	input  wire  [cart_pkg::INDEX_W-1:0]     ioctl_index,
	input  wire                              img_mounted,
	input  wire                              img_readonly,
	input  wire  [cart_pkg::IMG_SIZE_W-1:0]  img_size,
	input  wire                              bk_load,
	input  wire                              bk_save,
	input  wire  cart_pkg::mask_t            ram_mask,
	input  wire                              clearing_ram,
	input  wire                              bk_loading,
	output logic                             cart_dl,
	output logic                             code_dl,
	output logic                             clear_start,
	output logic                             start_load,
	output logic                             start_save,
	output logic                             sys_reset
);

	import cart_pkg::*;

	logic old_cart_dl;
	logic old_load;
	logic old_save;
	logic bk_ena;
	logic dl_end;
	logic load_rise;
	logic save_rise;

	// ========================================================================
	// Download decode
	// ========================================================================
	assign cart_dl = ioctl_download & (ioctl_index[5:0] == CART_INDEX);
	assign code_dl = ioctl_download & (ioctl_index == CODE_INDEX);

	assign clear_start = cart_dl & ~old_cart_dl;
	assign dl_end      = old_cart_dl & ~cart_dl;

	// ========================================================================
	// Backup enable and request edges
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_cart_dl <= 1'b0;
			old_load    <= 1'b0;
			old_save    <= 1'b0;
			bk_ena      <= 1'b0;
		end else begin
			old_cart_dl <= cart_dl;
			old_load    <= bk_load & bk_ena;
			old_save    <= bk_save & bk_ena;
			if (clear_start)
				bk_ena <= 1'b0;
			// Save image is mounted by the end of the download
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
		end
	end

	assign load_rise = bk_load & bk_ena & ~old_load;
	assign save_rise = bk_save & bk_ena & ~old_save;

	// Automatic load once the cartridge is in
	assign start_load = load_rise | (dl_end & (|img_size) & bk_ena);
	assign start_save = save_rise;

	assign sys_reset = RESET | cart_dl | clearing_ram | bk_loading;

endmodule

`default_nettype wire

//--- src/cart_loader_top.sv
// Cartridge loader top level joining control, parser, RAM fill, cheats and backup
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top #(
	parameter int FILL_BITS = 17
) (
	input  wire                                clk_sys,
	input  wire                                RESET,
	input  wire                                ioctl_download,
	input  wire  [cart_pkg::INDEX_W-1:0]       ioctl_index,
	input  wire  [cart_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  wire  [cart_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
	input  wire                                ioctl_wr,
	input  wire  cart_pkg::header_mode_t       header_mode,
	input  wire  cart_pkg::region_sel_t        region_sel,
	input  wire  cart_pkg::fill_pattern_t      fill_pattern,
	input  wire                                bk_load,
	input  wire                                bk_save,
	input  wire                                img_mounted,
	input  wire                                img_readonly,
	input  wire  [cart_pkg::IMG_SIZE_W-1:0]    img_size,
	input  wire                                sd_ack,
	output cart_pkg::rom_type_t                rom_type,
	output cart_pkg::mask_t                    rom_mask,
	output cart_pkg::mask_t                    ram_mask,
	output logic                               pal,
	output logic                               clearing_ram,
	output logic [FILL_BITS-1:0]               fill_addr,
	output logic [7:0]                         fill_data,
	output cart_pkg::cheat_code_t              cheat_code,
	output logic                               cheat_strobe,
	output logic [cart_pkg::SD_LBA_W-1:0]      sd_lba,
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic                               bk_loading,
	output logic                               sys_reset
);

	logic cart_dl;
	logic code_dl;
	logic clear_start;
	logic start_load;
	logic start_save;

	// ========================================================================
	// Download control and reset
	// ========================================================================
	cart_load_ctrl i_cart_load_ctrl (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.bk_load        (bk_load),
		.bk_save        (bk_save),
		.ram_mask       (ram_mask),
		.clearing_ram   (clearing_ram),
		.bk_loading     (bk_loading),
		.cart_dl        (cart_dl),
		.code_dl        (code_dl),
		.clear_start    (clear_start),
		.start_load     (start_load),
		.start_save     (start_save),
		.sys_reset      (sys_reset)
	);

	header_parser i_header_parser (
		.clk_sys     (clk_sys),
		.cart_dl     (cart_dl),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	ram_clear_fill #(
		.FILL_BITS (FILL_BITS)
	) i_ram_clear_fill (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.clear_start  (clear_start),
		.fill_pattern (fill_pattern),
		.clearing_ram (clearing_ram),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data)
	);

	cheat_code_assembler i_cheat_code_assembler (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.code_dl      (code_dl),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe)
	);

	backup_sector_sequencer i_backup_sector_sequencer (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.start_load (start_load),
		.start_save (start_save),
		.ram_mask   (ram_mask),
		.sd_ack     (sd_ack),
		.sd_lba     (sd_lba),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.bk_loading (bk_loading)
	);

endmodule

`default_nettype wire

//--- src/cart_pkg.sv
// Cartridge loader package with header, mask, cheat and fill types and constants
`default_nettype none

package cart_pkg;

	// Host download bus and card interface widths
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;
	localparam int INDEX_W      = 8;
	localparam int IMG_SIZE_W   = 64;
	localparam int SD_LBA_W     = 32;

	// Download kinds
	localparam logic [INDEX_W-1:0] CODE_INDEX = '1;
	localparam logic [5:0]         CART_INDEX = 6'd0;

	// ========================================================================
	// ROM header layout
	// ========================================================================
	localparam logic [IOCTL_ADDR_W-1:0] HEADER_SKIP     = 25'h200;
	localparam logic [IOCTL_ADDR_W-1:0] LOROM_ROM_OFS   = 25'h7FD6;
	localparam logic [IOCTL_ADDR_W-1:0] LOROM_RAM_OFS   = 25'h7FD8;
	localparam logic [IOCTL_ADDR_W-1:0] HIROM_ROM_OFS   = 25'hFFD6;
	localparam logic [IOCTL_ADDR_W-1:0] HIROM_RAM_OFS   = 25'hFFD8;
	localparam logic [IOCTL_ADDR_W-1:0] EXHIROM_ROM_OFS = 25'h40FFD6;
	localparam logic [IOCTL_ADDR_W-1:0] EXHIROM_RAM_OFS = 25'h40FFD8;

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

	typedef enum logic [1:0] {
		REG_AUTO = 2'd0,
		REG_NTSC = 2'd1,
		REG_PAL  = 2'd2
	} region_sel_t;

	// Power-on work RAM contents
	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_pattern_t;

	typedef logic [23:0] mask_t;
	typedef logic [7:0]  rom_type_t;

	// Mask is (MASK_UNIT << size code) - 1
	localparam mask_t      MASK_UNIT        = 24'd1024;
	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;
	localparam int         SECTOR_SHIFT     = 9;

	// Cheat record, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

//--- src/cheat_code_assembler.sv
// Cheat code assembler collecting eight half-words into one 128-bit record
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  wire                                clk_sys,
	input  wire                                RESET,
	input  wire                                code_dl,
	input  wire                                ioctl_wr,
	input  wire  [cart_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  wire  [cart_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
	output cart_pkg::cheat_code_t              cheat_code,
	output logic                               cheat_strobe
);

	import cart_pkg::*;

	logic code_wr;

	assign code_wr = code_dl & ioctl_wr;

	// Last half-word completes the record
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= code_wr & (ioctl_addr[3:0] == 4'd14);
	end

	// Low half first for each field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= ioctl_dout;
				4'd2:  cheat_code.flags[31:16]   <= ioctl_dout;
				4'd4:  cheat_code.addr[15:0]     <= ioctl_dout;
				4'd6:  cheat_code.addr[31:16]    <= ioctl_dout;
				4'd8:  cheat_code.compare[15:0]  <= ioctl_dout;
				4'd10: cheat_code.compare[31:16] <= ioctl_dout;
				4'd12: cheat_code.replace[15:0]  <= ioctl_dout;
				4'd14: cheat_code.replace[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/header_parser.sv
// ROM header parser producing mapper type, address masks and video region
`timescale 1ns/1ps
`default_nettype none

module header_parser (
	input  wire                                clk_sys,
	input  wire                                cart_dl,
	input  wire                                ioctl_wr,
	input  wire  [cart_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  wire  [cart_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
	input  wire  cart_pkg::header_mode_t       header_mode,
	input  wire  cart_pkg::region_sel_t        region_sel,
	output cart_pkg::rom_type_t                rom_type,
	output cart_pkg::mask_t                    rom_mask,
	output cart_pkg::mask_t                    ram_mask,
	output logic                               pal
);

	import cart_pkg::*;

	logic [3:0]              rom_size;
	logic [3:0]              ram_size;
	logic [3:0]              rom_size_nxt;
	logic [3:0]              ram_size_nxt;
	logic                    rom_region;
	logic                    ofs_valid;
	logic [IOCTL_ADDR_W-1:0] rom_ofs;
	logic [IOCTL_ADDR_W-1:0] ram_ofs;

	function automatic mask_t size_to_mask(input logic [3:0] size);
		size_to_mask = (MASK_UNIT << size) - mask_t'(1);
	endfunction

	// Size fields in the internal header, per mapping
	always_comb begin
		ofs_valid = 1'b1;
		rom_ofs   = LOROM_ROM_OFS;
		ram_ofs   = LOROM_RAM_OFS;
		case (header_mode)
			HDR_LOROM: begin
				rom_ofs = LOROM_ROM_OFS;
				ram_ofs = LOROM_RAM_OFS;
			end
			HDR_HIROM: begin
				rom_ofs = HIROM_ROM_OFS;
				ram_ofs = HIROM_RAM_OFS;
			end
			HDR_EXHIROM: begin
				rom_ofs = EXHIROM_ROM_OFS;
				ram_ofs = EXHIROM_RAM_OFS;
			end
			default: ofs_valid = 1'b0;
		endcase
	end

	// Next sizes for the current write
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (ioctl_addr == '0) begin
			rom_size_nxt = DEFAULT_ROM_SIZE;
			ram_size_nxt = 4'h0;
			// Loader header carries both sizes in the low byte
			if (header_mode == HDR_AUTO && ioctl_dout[7:0] != 8'h00)
				{ram_size_nxt, rom_size_nxt} = ioctl_dout[7:0];
		end
		if (ofs_valid && ioctl_addr == rom_ofs + HEADER_SKIP)
			rom_size_nxt = ioctl_dout[11:8];
		if (ofs_valid && ioctl_addr == ram_ofs + HEADER_SKIP)
			ram_size_nxt = ioctl_dout[3:0];
	end

	// ========================================================================
	// Field capture
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (cart_dl) begin
			if (ioctl_wr) begin
				rom_size <= rom_size_nxt;
				ram_size <= ram_size_nxt;
				rom_mask <= size_to_mask(rom_size_nxt);
				ram_mask <= (ram_size_nxt != 4'h0) ? size_to_mask(ram_size_nxt) : mask_t'(0);
				if (ioctl_addr == '0) begin
					case (header_mode)
						HDR_NONE,
						HDR_LOROM:   rom_type <= 8'd0;
						HDR_HIROM:   rom_type <= 8'd1;
						HDR_EXHIROM: rom_type <= 8'd2;
						default:     rom_type <= ioctl_dout[15:8];
					endcase
				end
				if (ioctl_addr == IOCTL_ADDR_W'(2))
					rom_region <= ioctl_dout[8];
			end
		end else begin
			case (region_sel)
				REG_AUTO: pal <= rom_region;
				REG_NTSC: pal <= 1'b0;
				default:  pal <= 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/ram_clear_fill.sv
// Work RAM clear sequencer with selectable power-on fill pattern
`timescale 1ns/1ps
`default_nettype none

module ram_clear_fill #(
	parameter int FILL_BITS = 17
) (
	input  wire                         clk_sys,
	input  wire                         RESET,
	input  wire                         clear_start,
	input  wire  cart_pkg::fill_pattern_t fill_pattern,
	output logic                        clearing_ram,
	output logic [FILL_BITS-1:0]        fill_addr,
	output logic [7:0]                  fill_data
);

	import cart_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing_ram <= 1'b0;
			fill_addr    <= '0;
		end else begin
			if (clearing_ram && (&fill_addr))
				clearing_ram <= 1'b0;
			if (clear_start)
				clearing_ram <= 1'b1;
			if (clearing_ram)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	// Pattern byte for the current address
	always_comb begin
		case (fill_pattern)
			FILL_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			FILL_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			FILL_55:   fill_data = 8'h55;
			default:   fill_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- testbench/tb_cart_loader_checks.svh
// Testbench compare tasks and expected-value rules for the cartridge loader
`ifndef TB_CART_LOADER_CHECKS_SVH
`define TB_CART_LOADER_CHECKS_SVH

task automatic stop_on_failure(input string msg);
	$display("%s", msg);
	$display("Test failures found");
	$fatal(1, "Simulation stopped on first error");
endtask

task automatic check_mask(input string what, input mask_t got, input mask_t exp);
	if (got !== exp)
		stop_on_failure($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_type(input string what, input rom_type_t got, input rom_type_t exp);
	if (got !== exp)
		stop_on_failure($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_code(input string what, input cheat_code_t got, input cheat_code_t exp);
	if (got !== exp)
		stop_on_failure($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_lba(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		stop_on_failure($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp)
		stop_on_failure($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic check_count(input string what, input int got, input int exp);
	if (got != exp)
		stop_on_failure($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
endtask

// Size code n covers 1 KiB << n
function automatic mask_t size_mask(input logic [3:0] code);
	size_mask = mask_t'((32'd1024 << code) - 32'd1);
endfunction

function automatic logic [7:0] expected_fill(input fill_pattern_t pat, input int addr);
	case (pat)
		FILL_9966: expected_fill = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
		FILL_00FF: expected_fill = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
		FILL_55:   expected_fill = 8'h55;
		default:   expected_fill = 8'hFF;
	endcase
endfunction

`endif

//--- testbench/tb_cart_loader.sv
// Testbench for the cartridge loader with header table, RAM fill, cheats and backup checks
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader;

	import cart_pkg::*;

	localparam int FILL_BITS     = 10;
	localparam int NUM_ROWS      = 6;
	localparam int MAX_ACK_DELAY = 4;
	localparam int MAX_SECTORS   = 16;
	localparam int WORDS_PER_DL  = 24;
	localparam int TIMEOUT_CYCLES = (NUM_ROWS + 1) * ((1 << FILL_BITS) + WORDS_PER_DL
		+ 2 * MAX_SECTORS * (2 * MAX_ACK_DELAY + 4)) + 2000;

	typedef struct packed {
		header_mode_t  mode;
		region_sel_t   region;
		fill_pattern_t fill;
		logic [15:0]   w0;
		logic [15:0]   w2;
		logic [15:0]   rom_w;
		logic [15:0]   ram_w;
		logic          mounted;
		logic          readonly;
		logic          sized;
		rom_type_t     exp_type;
		mask_t         exp_rom;
		mask_t         exp_ram;
		logic          exp_pal;
		int            exp_loads;
		int            exp_saves;
	} row_t;

	`include "tb_cart_loader_checks.svh"

	logic clk_sys = 1'b0;
	logic RESET;
	logic ioctl_download;
	logic [INDEX_W-1:0] ioctl_index;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [IOCTL_DATA_W-1:0] ioctl_dout;
	logic ioctl_wr;
	header_mode_t header_mode;
	region_sel_t region_sel;
	fill_pattern_t fill_pattern;
	logic bk_load;
	logic bk_save;
	logic img_mounted;
	logic img_readonly;
	logic [IMG_SIZE_W-1:0] img_size;
	logic sd_ack;
	rom_type_t rom_type;
	mask_t rom_mask;
	mask_t ram_mask;
	logic pal;
	logic clearing_ram;
	logic [FILL_BITS-1:0] fill_addr;
	logic [7:0] fill_data;
	cheat_code_t cheat_code;
	logic cheat_strobe;
	logic [SD_LBA_W-1:0] sd_lba;
	logic sd_rd;
	logic sd_wr;
	logic bk_loading;
	logic sys_reset;

	row_t rows [NUM_ROWS];
	logic [31:0] req_lba [$];
	logic req_wr [$];
	int fill_count = 0;
	int last_fill_len = 0;
	int clear_runs = 0;
	int strobe_count = 0;
	int cycle_count = 0;
	logic was_clearing = 1'b0;

	cart_loader_top #(.FILL_BITS(FILL_BITS)) i_cart_loader_top (.*);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			stop_on_failure("Timeout: the run took longer than the cycle limit");
	end

	// Fill sequence, strobe count and reset combination on the falling edge
	always @(negedge clk_sys) begin
		if (!RESET) begin
			if (clearing_ram) begin
				check_count("fill_addr", int'(fill_addr), fill_count);
				check_type("fill_data", fill_data, expected_fill(fill_pattern, fill_count));
				fill_count <= fill_count + 1;
			end else if (was_clearing) begin
				last_fill_len <= fill_count;
				clear_runs    <= clear_runs + 1;
				fill_count    <= 0;
			end
			was_clearing <= clearing_ram;
			if (cheat_strobe)
				strobe_count <= strobe_count + 1;
		end
		check_bit("sys_reset", sys_reset, RESET | (ioctl_download & (ioctl_index[5:0] == 6'd0))
			| clearing_ram | bk_loading);
	end

	// SD card model with random ack latency
	initial begin : sd_card_model
		logic [31:0] lba;
		logic        wr;
		int          delay;
		sd_ack = 1'b0;
		void'($urandom(32'h00fb22ac));
		forever begin
			@(negedge clk_sys);
			if (!RESET && (sd_rd || sd_wr) && !sd_ack) begin
				lba   = sd_lba;
				wr    = sd_wr;
				check_bit("bk_loading during request", bk_loading, ~wr);
				delay = int'($urandom_range(1, MAX_ACK_DELAY));
				repeat (delay) @(posedge clk_sys);
				req_lba.push_back(lba);
				req_wr.push_back(wr);
				sd_ack <= 1'b1;
				delay = int'($urandom_range(1, MAX_ACK_DELAY));
				repeat (delay) @(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	function automatic row_t make_row(input header_mode_t mode, input region_sel_t region,
		input fill_pattern_t fill, input logic [15:0] w0, input logic [15:0] w2,
		input logic [15:0] rom_w, input logic [15:0] ram_w, input logic [2:0] flags);
		row_t rw;
		logic [3:0] rom_code;
		logic [3:0] ram_code;
		logic writable;
		int sectors;
		rw = '0;
		rw.mode = mode;
		rw.region = region;
		rw.fill = fill;
		rw.w0 = w0;
		rw.w2 = w2;
		rw.rom_w = rom_w;
		rw.ram_w = ram_w;
		{rw.mounted, rw.readonly, rw.sized} = flags;
		rom_code = 4'hC;
		ram_code = 4'h0;
		if (mode == HDR_AUTO && w0[7:0] != 8'h00)
			{ram_code, rom_code} = w0[7:0];
		case (mode)
			HDR_NONE, HDR_LOROM: rw.exp_type = 8'd0;
			HDR_HIROM:           rw.exp_type = 8'd1;
			HDR_EXHIROM:         rw.exp_type = 8'd2;
			default:             rw.exp_type = w0[15:8];
		endcase
		if (mode == HDR_LOROM || mode == HDR_HIROM || mode == HDR_EXHIROM) begin
			rom_code = rom_w[11:8];
			ram_code = ram_w[3:0];
		end
		rw.exp_rom = size_mask(rom_code);
		rw.exp_ram = (ram_code == 4'h0) ? mask_t'(0) : size_mask(ram_code);
		rw.exp_pal = (region == REG_AUTO) ? w2[8] : (region == REG_PAL);
		writable = rw.mounted && !rw.readonly && (rw.exp_ram != mask_t'(0));
		sectors = int'(rw.exp_ram[23:9]) + 1;
		rw.exp_saves = writable ? sectors : 0;
		rw.exp_loads = (writable && rw.sized) ? sectors : 0;
		make_row = rw;
	endfunction

	task automatic write_word(input logic [IOCTL_ADDR_W-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic wait_backup(input int base, input int count, input logic exp_wr);
		while (!((req_lba.size() - base >= count) && !bk_loading && !sd_ack && !sd_rd && !sd_wr))
			@(negedge clk_sys);
		repeat (20) @(negedge clk_sys);
		check_count("sector requests", req_lba.size() - base, count);
		for (int i = 0; i < count; i++) begin
			check_lba("sd_lba", req_lba[base + i], 32'(i));
			check_bit("sd_wr request", req_wr[base + i], exp_wr);
		end
	endtask

	task automatic run_row(input row_t rw);
		logic [IOCTL_ADDR_W-1:0] rom_ofs;
		logic [IOCTL_ADDR_W-1:0] ram_ofs;
		int base;
		int runs;
		rom_ofs = (rw.mode == HDR_HIROM) ? HIROM_ROM_OFS :
			(rw.mode == HDR_EXHIROM) ? EXHIROM_ROM_OFS : LOROM_ROM_OFS;
		ram_ofs = rom_ofs + IOCTL_ADDR_W'(2);
		base = req_lba.size();
		runs = clear_runs;
		@(posedge clk_sys);
		header_mode    <= rw.mode;
		region_sel     <= rw.region;
		fill_pattern   <= rw.fill;
		img_mounted    <= rw.mounted;
		img_readonly   <= rw.readonly;
		img_size       <= rw.sized ? 64'd8192 : 64'd0;
		ioctl_index    <= '0;
		ioctl_download <= 1'b1;
		write_word('0, rw.w0);
		write_word(IOCTL_ADDR_W'(2), rw.w2);
		write_word(rom_ofs + HEADER_SKIP, rw.rom_w);
		write_word(ram_ofs + HEADER_SKIP, rw.ram_w);
		repeat (3) @(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(negedge clk_sys);
		check_type("rom_type", rom_type, rw.exp_type);
		check_mask("rom_mask", rom_mask, rw.exp_rom);
		check_mask("ram_mask", ram_mask, rw.exp_ram);
		check_bit("pal", pal, rw.exp_pal);
		while (clear_runs == runs)
			@(negedge clk_sys);
		check_count("clearing_ram length", last_fill_len, 1 << FILL_BITS);
		wait_backup(base, rw.exp_loads, 1'b0);
		check_bit("sys_reset after load", sys_reset, 1'b0);
		// Manual save from the menu
		base = req_lba.size();
		@(posedge clk_sys);
		bk_save <= 1'b1;
		repeat (4) @(posedge clk_sys);
		bk_save <= 1'b0;
		wait_backup(base, rw.exp_saves, 1'b1);
	endtask

	task automatic send_cheat(input cheat_code_t code, input logic [IOCTL_ADDR_W-1:0] start);
		int strobes;
		strobes = strobe_count;
		@(posedge clk_sys);
		ioctl_index    <= '1;
		ioctl_download <= 1'b1;
		for (int k = 0; k < 8; k++)
			write_word(start + IOCTL_ADDR_W'(2 * k), code[(3 - k / 2) * 32 + (k % 2) * 16 +: 16]);
		repeat (3) @(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(negedge clk_sys);
		check_count("cheat_strobe pulses", strobe_count - strobes, 1);
		check_code("cheat_code", cheat_code, code);
	endtask

	initial begin : main
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		header_mode = HDR_AUTO;
		region_sel = REG_AUTO;
		fill_pattern = FILL_9966;
		bk_load = 1'b0;
		bk_save = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		// Flags are mounted, read-only, nonzero image size
		rows[0] = make_row(HDR_AUTO, REG_AUTO, FILL_9966, 16'h2131, 16'h0100, 16'h0, 16'h0, 3'b101);
		rows[1] = make_row(HDR_AUTO, REG_AUTO, FILL_00FF, 16'h3500, 16'h0000, 16'h0, 16'h0, 3'b101);
		rows[2] = make_row(HDR_NONE, REG_PAL, FILL_55, 16'h4477, 16'h0100, 16'h0, 16'h0, 3'b000);
		rows[3] = make_row(HDR_LOROM, REG_NTSC, FILL_FF, 16'h0012, 16'h0100, 16'h0A00, 16'h0001,
			3'b101);
		rows[4] = make_row(HDR_HIROM, REG_AUTO, FILL_9966, 16'h0000, 16'h0000, 16'h0B00, 16'h0002,
			3'b111);
		rows[5] = make_row(HDR_EXHIROM, REG_PAL, FILL_00FF, 16'h0000, 16'h0100, 16'h0900,
			16'h0002, 3'b100);
		repeat (2) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_bit("clearing_ram after reset", clearing_ram, 1'b0);
		check_bit("cheat_strobe after reset", cheat_strobe, 1'b0);
		check_bit("sd_rd after reset", sd_rd, 1'b0);
		check_bit("sd_wr after reset", sd_wr, 1'b0);
		check_bit("bk_loading after reset", bk_loading, 1'b0);
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(rows[r]);
		send_cheat({32'h0000_0001, 32'h007E_0F10, 32'h0000_0000, 32'h0000_0063}, '0);
		send_cheat({32'h8000_0002, 32'h00C0_1234, 32'h0000_00AA, 32'h0000_5555}, 25'h10);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+testbench
src/cart_pkg.sv
src/cart_load_ctrl.sv
src/header_parser.sv
src/ram_clear_fill.sv
src/cheat_code_assembler.sv
src/backup_sector_sequencer.sv
src/cart_loader_top.sv
testbench/tb_cart_loader.sv
